// ==== include/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// bus widths
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32
`define BRIDGE_ID_W 4

// slave memory
`define BRIDGE_MEM_WORDS 1024
`define BRIDGE_RD_LAT 2   // ar handshake to rvalid, at least 2

`endif

// ==== source/axi_pkg.sv ====
`include "bridge_cfg.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   arid;
        logic [`BRIDGE_ADDR_W-1:0] araddr;
        logic [7:0]                arlen;   // beats minus one
        logic [2:0]                arsize;
        axi_burst_e                arburst;
        logic [1:0]                arlock;
        logic [3:0]                arcache;
        logic [2:0]                arprot;
    } axi_ar_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   awid;
        logic [`BRIDGE_ADDR_W-1:0] awaddr;
        logic [7:0]                awlen;
        logic [2:0]                awsize;
        axi_burst_e                awburst;
        logic [1:0]                awlock;
        logic [3:0]                awcache;
        logic [2:0]                awprot;
    } axi_aw_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]     wid;
        logic [`BRIDGE_DATA_W-1:0]   wdata;
        logic [`BRIDGE_DATA_W/8-1:0] wstrb;
        logic                        wlast;
    } axi_w_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0]   rid;
        logic [`BRIDGE_DATA_W-1:0] rdata;
        logic [1:0]                rresp;
        logic                      rlast;
    } axi_r_t;

    typedef struct packed {
        logic [`BRIDGE_ID_W-1:0] bid;
        logic [1:0]              bresp;
    } axi_b_t;

endpackage

// ==== source/sram_if_pkg.sv ====
`include "bridge_cfg.svh"

package sram_if_pkg;

    // value doubles as the low id bit on the bus
    typedef enum logic {
        PORT_INST = 1'b0,
        PORT_DATA = 1'b1
    } sram_port_e;

    typedef struct packed {
        logic                        req;
        logic                        wr;
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic [`BRIDGE_DATA_W/8-1:0] wstrb;
        logic [`BRIDGE_DATA_W-1:0]   wdata;
    } sram_req_t;

    typedef struct packed {
        logic                      addr_ok;
        logic                      data_ok;
        logic [`BRIDGE_DATA_W-1:0] rdata;
    } sram_rsp_t;

    typedef struct packed {
        sram_port_e                port;
        logic [`BRIDGE_ADDR_W-1:0] addr;
    } rd_cmd_t;

    typedef struct packed {
        sram_port_e                port;
        logic [`BRIDGE_DATA_W-1:0] rdata;
    } rd_done_t;

    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0]   addr;
        logic [`BRIDGE_DATA_W/8-1:0] wstrb;
        logic [`BRIDGE_DATA_W-1:0]   wdata;
    } wr_cmd_t;

    // one-hot channel machines
    typedef enum logic [2:0] {AR_IDLE = 3'b001, AR_REQ = 3'b010, AR_END = 3'b100} ar_state_e;
    typedef enum logic [2:0] {R_IDLE = 3'b001, R_DATA = 3'b010, R_END = 3'b100} r_state_e;
    typedef enum logic [2:0] {B_IDLE = 3'b001, B_WAIT = 3'b010, B_END = 3'b100} b_state_e;

    typedef enum logic [4:0] {
        W_IDLE      = 5'b00001,
        W_START     = 5'b00010,
        W_ADDR_DONE = 5'b00100,
        W_DATA_DONE = 5'b01000,
        W_END       = 5'b10000
    } w_state_e;

    // read side of the slave memory
    typedef enum logic [1:0] {RAM_IDLE, RAM_WAIT, RAM_RESP} axi_ram_state_e;

endpackage

// ==== source/sram_req_arbiter.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module sram_req_arbiter
    import sram_if_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  sram_req_t                 inst_req,
    input  sram_req_t                 data_req,
    input  logic                      rd_accept,
    input  sram_port_e                rd_accept_port,
    input  logic                      rd_done_valid,
    input  rd_done_t                  rd_done,
    input  logic                      wr_accept,
    input  logic                      wr_done,
    input  logic                      wr_pending,
    input  logic [`BRIDGE_ADDR_W-1:0] wr_pending_addr,
    output logic                      rd_cmd_valid,
    output rd_cmd_t                   rd_cmd,
    output logic                      wr_cmd_valid,
    output wr_cmd_t                   wr_cmd,
    output sram_rsp_t                 inst_rsp,
    output sram_rsp_t                 data_rsp
);
    logic inst_hit, data_hit;
    logic inst_rd, data_rd, data_wr;

    // reads wait for a write to the same word to get its response
    assign inst_hit = wr_pending && (inst_req.addr == wr_pending_addr);
    assign data_hit = wr_pending && (data_req.addr == wr_pending_addr);

    assign inst_rd = inst_req.req & ~inst_hit;   // inst wr bit ignored
    assign data_rd = data_req.req & ~data_req.wr & ~data_hit;
    assign data_wr = data_req.req & data_req.wr;

    // registered read grant, held until the ar handshake
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_cmd_valid <= 1'b0;
        end else if (rd_accept) begin
            rd_cmd_valid <= 1'b0;   // no regrant while the port still shows this req
        end else if (data_rd || inst_rd) begin
            rd_cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rd_cmd_valid) begin
            rd_cmd.port <= data_rd ? PORT_DATA : PORT_INST;   // data wins ties
            rd_cmd.addr <= data_rd ? data_req.addr : inst_req.addr;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_cmd_valid <= 1'b0;
        end else if (wr_accept) begin
            wr_cmd_valid <= 1'b0;
        end else if (data_wr) begin
            wr_cmd_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!wr_cmd_valid) begin
            wr_cmd <= '{addr: data_req.addr, wstrb: data_req.wstrb, wdata: data_req.wdata};
        end
    end

    // route handshakes back by port
    assign inst_rsp.addr_ok = rd_accept & (rd_accept_port == PORT_INST);
    assign inst_rsp.data_ok = rd_done_valid & (rd_done.port == PORT_INST);
    assign inst_rsp.rdata   = rd_done.rdata;

    assign data_rsp.addr_ok = (rd_accept & (rd_accept_port == PORT_DATA)) | wr_accept;
    assign data_rsp.data_ok = (rd_done_valid & (rd_done.port == PORT_DATA)) | wr_done;
    assign data_rsp.rdata   = rd_done.rdata;

endmodule

// ==== source/axi_read_master.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module axi_read_master
    import axi_pkg::*, sram_if_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  logic       rd_cmd_valid,
    input  rd_cmd_t    rd_cmd,
    input  logic       ar_ready,
    input  logic       r_valid,
    input  axi_r_t     r,
    output logic       ar_valid,
    output axi_ar_t    ar,
    output logic       r_ready,
    output logic       rd_accept,
    output sram_port_e rd_accept_port,
    output logic       rd_done_valid,
    output rd_done_t   rd_done
);
    ar_state_e ar_state, ar_next;
    r_state_e  r_state, r_next;

    logic [1:0]                out_cnt;   // accepted reads without their r beat
    sram_port_e                ar_port;
    logic [`BRIDGE_ADDR_W-1:0] ar_addr;
    logic [`BRIDGE_DATA_W-1:0] rd_buf [2];   // one entry per port
    sram_port_e                r_port;
    logic                      ar_hs, r_hs;

    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ar_state <= AR_IDLE;
            r_state  <= R_IDLE;
        end else begin
            ar_state <= ar_next;
            r_state  <= r_next;
        end
    end

    always_comb begin
        ar_next = ar_state;
        case (ar_state)
            AR_IDLE: if (rd_cmd_valid && out_cnt == 2'd0) ar_next = AR_REQ;
            AR_REQ:  if (ar_hs) ar_next = AR_END;
            AR_END:  ar_next = AR_IDLE;
            default: ar_next = AR_IDLE;
        endcase
    end

    always_comb begin
        r_next = r_state;
        case (r_state)
            R_IDLE:  if (out_cnt != 2'd0) r_next = R_DATA;
            R_DATA:  if (r_hs && r.rlast) r_next = R_END;
            R_END:   r_next = R_IDLE;
            default: r_next = R_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            out_cnt <= 2'd0;
        end else if (ar_hs && r_hs && r.rlast) begin
            out_cnt <= out_cnt;
        end else if (ar_hs) begin
            out_cnt <= out_cnt + 2'd1;
        end else if (r_hs && r.rlast) begin
            out_cnt <= out_cnt - 2'd1;
        end
    end

    // command frozen once the ar machine leaves idle
    always_ff @(posedge aclk) begin
        if (ar_state == AR_IDLE) begin
            ar_port <= rd_cmd.port;
            ar_addr <= rd_cmd.addr;
        end
    end

    assign ar_valid = (ar_state == AR_REQ);
    assign ar = '{
        arid:    {{(`BRIDGE_ID_W-1){1'b0}}, ar_port},
        araddr:  ar_addr,
        arlen:   8'd0,   // single beat
        arsize:  3'd2,   // whole word
        arburst: INCR,
        arlock:  2'b00,
        arcache: 4'b0000,
        arprot:  3'b000
    };

    assign rd_accept      = ar_hs;
    assign rd_accept_port = ar_port;

    assign r_ready = (r_state == R_DATA);

    always_ff @(posedge aclk) begin
        if (r_hs) begin
            rd_buf[r.rid[0]] <= r.rdata;
            r_port           <= sram_port_e'(r.rid[0]);
        end
    end

    // data_ok one cycle after the last beat, out of the buffer
    assign rd_done_valid = (r_state == R_END);
    assign rd_done.port  = r_port;
    assign rd_done.rdata = rd_buf[r_port];

endmodule

// ==== source/axi_write_master.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module axi_write_master
    import axi_pkg::*, sram_if_pkg::*;
(
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      wr_cmd_valid,
    input  wr_cmd_t                   wr_cmd,
    input  logic                      aw_ready,
    input  logic                      w_ready,
    input  logic                      b_valid,
    input  axi_b_t                    b,
    output logic                      aw_valid,
    output axi_aw_t                   aw,
    output logic                      w_valid,
    output axi_w_t                    w,
    output logic                      b_ready,
    output logic                      wr_accept,
    output logic                      wr_done,
    output logic                      wr_pending,
    output logic [`BRIDGE_ADDR_W-1:0] wr_pending_addr
);
    w_state_e w_state, w_next;
    wr_cmd_t  cmd_q;
    logic     aw_hs, w_hs, b_hs;

    assign aw_hs = aw_valid & aw_ready;
    assign w_hs  = w_valid & w_ready;
    assign b_hs  = b_valid & b_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            w_state <= W_IDLE;
        end else begin
            w_state <= w_next;
        end
    end

    // aw and w may finish in either order or together
    always_comb begin
        w_next = w_state;
        case (w_state)
            W_IDLE: if (wr_cmd_valid) w_next = W_START;
            W_START: begin
                if (aw_hs && w_hs) begin
                    w_next = W_END;
                end else if (aw_hs) begin
                    w_next = W_ADDR_DONE;
                end else if (w_hs) begin
                    w_next = W_DATA_DONE;
                end
            end
            W_ADDR_DONE: if (w_hs) w_next = W_END;
            W_DATA_DONE: if (aw_hs) w_next = W_END;
            W_END:       if (b_hs) w_next = W_IDLE;   // response state
            default:     w_next = W_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (w_state == W_IDLE) begin
            cmd_q <= wr_cmd;
        end
    end

    assign aw_valid = (w_state == W_START) || (w_state == W_DATA_DONE);
    assign w_valid  = (w_state == W_START) || (w_state == W_ADDR_DONE);
    assign b_ready  = (w_state == W_END);

    assign aw = '{
        awid:    {{(`BRIDGE_ID_W-1){1'b0}}, PORT_DATA},
        awaddr:  cmd_q.addr,
        awlen:   8'd0,
        awsize:  3'd2,
        awburst: INCR,
        awlock:  2'b00,
        awcache: 4'b0000,
        awprot:  3'b000
    };
    assign w = '{
        wid:   {{(`BRIDGE_ID_W-1){1'b0}}, PORT_DATA},
        wdata: cmd_q.wdata,
        wstrb: cmd_q.wstrb,
        wlast: 1'b1
    };

    assign wr_accept       = aw_hs;
    assign wr_done         = b_hs;
    assign wr_pending      = (w_state != W_IDLE);   // sample through b handshake
    assign wr_pending_addr = cmd_q.addr;

endmodule

// ==== source/axi_word_ram.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module axi_word_ram
    import axi_pkg::*, sram_if_pkg::*;
(
    input  logic    aclk,
    input  logic    aresetn,
    input  logic    ar_valid,
    input  axi_ar_t ar,
    input  logic    r_ready,
    input  logic    aw_valid,
    input  axi_aw_t aw,
    input  logic    w_valid,
    input  axi_w_t  w,
    input  logic    b_ready,
    output logic    ar_ready,
    output logic    r_valid,
    output axi_r_t  r,
    output logic    aw_ready,
    output logic    w_ready,
    output logic    b_valid,
    output axi_b_t  b
);
    localparam int         IDX_W    = $clog2(`BRIDGE_MEM_WORDS);
    localparam logic [3:0] LAT_LOAD = 4'(`BRIDGE_RD_LAT - 2);

    logic [`BRIDGE_DATA_W-1:0] mem [`BRIDGE_MEM_WORDS];

    axi_ram_state_e            rd_state;
    logic [3:0]                lat_cnt;
    logic [`BRIDGE_ID_W-1:0]   rd_id;
    logic [IDX_W-1:0]          rd_idx;
    logic [`BRIDGE_DATA_W-1:0] rd_data;
    logic                      ar_hs;

    logic                        aw_got, w_got;
    logic [`BRIDGE_ID_W-1:0]     wr_id, b_id;
    logic [IDX_W-1:0]            wr_idx, commit_idx;
    logic [`BRIDGE_DATA_W-1:0]   wr_data, commit_data;
    logic [`BRIDGE_DATA_W/8-1:0] wr_strb, commit_strb;
    logic                        aw_hs, w_hs, commit;

    // read side, one request at a time
    assign ar_ready = (rd_state == RAM_IDLE);
    assign r_valid  = (rd_state == RAM_RESP);
    assign ar_hs    = ar_valid & ar_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rd_state <= RAM_IDLE;
        end else begin
            case (rd_state)
                RAM_IDLE: if (ar_valid) rd_state <= RAM_WAIT;
                RAM_WAIT: if (lat_cnt == 4'd0) rd_state <= RAM_RESP;
                RAM_RESP: if (r_ready) rd_state <= RAM_IDLE;   // rvalid held until taken
                default:  rd_state <= RAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            lat_cnt <= LAT_LOAD;
            rd_id   <= ar.arid;
            rd_idx  <= ar.araddr[IDX_W+1:2];
        end else if (rd_state == RAM_WAIT && lat_cnt != 4'd0) begin
            lat_cnt <= lat_cnt - 4'd1;
        end
        if (rd_state == RAM_WAIT && lat_cnt == 4'd0) begin
            rd_data <= mem[rd_idx];
        end
    end

    assign r = '{rid: rd_id, rdata: rd_data, rresp: 2'b00, rlast: 1'b1};

    // write side, aw and w latched independently
    assign aw_ready = ~aw_got & ~b_valid;
    assign w_ready  = ~w_got & ~b_valid;
    assign aw_hs    = aw_valid & aw_ready;
    assign w_hs     = w_valid & w_ready;
    assign commit   = (aw_got | aw_hs) & (w_got | w_hs);

    assign commit_idx  = aw_got ? wr_idx : aw.awaddr[IDX_W+1:2];
    assign commit_data = w_got ? wr_data : w.wdata;
    assign commit_strb = w_got ? wr_strb : w.wstrb;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            aw_got <= commit ? 1'b0 : (aw_got | aw_hs);
            w_got  <= commit ? 1'b0 : (w_got | w_hs);
            if (commit) begin
                b_valid <= 1'b1;   // one cycle after the later of aw and w
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_hs) begin
            wr_id  <= aw.awid;
            wr_idx <= aw.awaddr[IDX_W+1:2];
        end
        if (w_hs) begin
            wr_data <= w.wdata;
            wr_strb <= w.wstrb;
        end
        if (commit) begin
            b_id <= aw_got ? wr_id : aw.awid;
        end
    end

    // byte merge on commit
    always_ff @(posedge aclk) begin
        if (commit) begin
            for (int i = 0; i < `BRIDGE_DATA_W / 8; i++) begin
                if (commit_strb[i]) begin
                    mem[commit_idx][i*8 +: 8] <= commit_data[i*8 +: 8];
                end
            end
        end
    end

    assign b = '{bid: b_id, bresp: 2'b00};

endmodule

// ==== source/sram_axi_bridge_top.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module sram_axi_bridge_top
    import axi_pkg::*, sram_if_pkg::*;
(
    input  logic      aclk,
    input  logic      aresetn,
    input  sram_req_t inst_req,
    input  sram_req_t data_req,
    output sram_rsp_t inst_rsp,
    output sram_rsp_t data_rsp
);
    // arbiter to masters
    logic                      rd_cmd_valid, rd_accept, rd_done_valid;
    rd_cmd_t                   rd_cmd;
    sram_port_e                rd_accept_port;
    rd_done_t                  rd_done;
    logic                      wr_cmd_valid, wr_accept, wr_done, wr_pending;
    wr_cmd_t                   wr_cmd;
    logic [`BRIDGE_ADDR_W-1:0] wr_pending_addr;

    // axi3 bus
    logic    ar_valid, ar_ready, r_valid, r_ready;
    logic    aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
    axi_ar_t ar;
    axi_r_t  r;
    axi_aw_t aw;
    axi_w_t  w;
    axi_b_t  b;

    sram_req_arbiter u_arbiter (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .inst_req       (inst_req),
        .data_req       (data_req),
        .rd_accept      (rd_accept),
        .rd_accept_port (rd_accept_port),
        .rd_done_valid  (rd_done_valid),
        .rd_done        (rd_done),
        .wr_accept      (wr_accept),
        .wr_done        (wr_done),
        .wr_pending     (wr_pending),
        .wr_pending_addr(wr_pending_addr),
        .rd_cmd_valid   (rd_cmd_valid),
        .rd_cmd         (rd_cmd),
        .wr_cmd_valid   (wr_cmd_valid),
        .wr_cmd         (wr_cmd),
        .inst_rsp       (inst_rsp),
        .data_rsp       (data_rsp)
    );

    axi_read_master u_read_master (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .rd_cmd_valid  (rd_cmd_valid),
        .rd_cmd        (rd_cmd),
        .ar_ready      (ar_ready),
        .r_valid       (r_valid),
        .r             (r),
        .ar_valid      (ar_valid),
        .ar            (ar),
        .r_ready       (r_ready),
        .rd_accept     (rd_accept),
        .rd_accept_port(rd_accept_port),
        .rd_done_valid (rd_done_valid),
        .rd_done       (rd_done)
    );

    axi_write_master u_write_master (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .wr_cmd_valid   (wr_cmd_valid),
        .wr_cmd         (wr_cmd),
        .aw_ready       (aw_ready),
        .w_ready        (w_ready),
        .b_valid        (b_valid),
        .b              (b),
        .aw_valid       (aw_valid),
        .aw             (aw),
        .w_valid        (w_valid),
        .w              (w),
        .b_ready        (b_ready),
        .wr_accept      (wr_accept),
        .wr_done        (wr_done),
        .wr_pending     (wr_pending),
        .wr_pending_addr(wr_pending_addr)
    );

    axi_word_ram u_ram (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ar_valid(ar_valid),
        .ar      (ar),
        .r_ready (r_ready),
        .aw_valid(aw_valid),
        .aw      (aw),
        .w_valid (w_valid),
        .w       (w),
        .b_ready (b_ready),
        .ar_ready(ar_ready),
        .r_valid (r_valid),
        .r       (r),
        .aw_ready(aw_ready),
        .w_ready (w_ready),
        .b_valid (b_valid),
        .b       (b)
    );

endmodule

// ==== bench/tb_bridge.sv ====
`timescale 1ns/1ns
`include "bridge_cfg.svh"

module tb_bridge
    import sram_if_pkg::*;
();
    typedef logic [`BRIDGE_ADDR_W-1:0]   addr_t;
    typedef logic [`BRIDGE_DATA_W-1:0]   word_t;
    typedef logic [`BRIDGE_DATA_W/8-1:0] strb_t;

    // one entry per request still owed a data_ok
    typedef struct packed {
        logic  is_wr;
        word_t value;
    } expect_t;

    localparam int    IDX_W      = $clog2(`BRIDGE_MEM_WORDS);
    localparam int    WIN_WORDS  = 32;             // words touched by the tests
    localparam addr_t WIN_BASE   = addr_t'('h400);
    localparam int    WAIT_LIMIT = 2000;           // cycles per wait

    logic        aclk;
    logic        aresetn;
    sram_req_t   inst_req, data_req;
    sram_rsp_t   inst_rsp, data_rsp;
    int unsigned cycle_count = 0;
    string       test_name = "reset";
    word_t       ref_mem [`BRIDGE_MEM_WORDS];
    expect_t     inst_q[$];
    expect_t     data_q[$];

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;   // 20 ns period

    always @(posedge aclk) cycle_count <= cycle_count + 1;

    sram_axi_bridge_top DUT (
        .aclk    (aclk),
        .aresetn (aresetn),
        .inst_req(inst_req),
        .data_req(data_req),
        .inst_rsp(inst_rsp),
        .data_rsp(data_rsp)
    );

    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'hA5C3_5A3C;
    endfunction

    // strobed bytes come from the new data, the rest stay
    function automatic word_t strobe_merge(word_t old, word_t wdata, strb_t strb);
        word_t res;
        res = old;
        for (int i = 0; i < `BRIDGE_DATA_W / 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = wdata[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic word_t ref_read(addr_t addr);
        return ref_mem[addr[IDX_W+1:2]];
    endfunction

    function automatic void ref_write(sram_req_t rq);
        logic [IDX_W-1:0] idx;
        idx          = rq.addr[IDX_W+1:2];
        ref_mem[idx] = strobe_merge(ref_mem[idx], rq.wdata, rq.wstrb);
    endfunction

    function automatic addr_t rand_addr();
        return WIN_BASE + addr_t'($urandom_range(0, WIN_WORDS - 1) * 4);
    endfunction

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_rdata(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %08h actual %08h", name, expected, actual);
            abort_run();
        end
    endtask

    // only the handshake bits, rdata is meaningless here
    task automatic check_rsp_idle(string name, sram_rsp_t expected, sram_rsp_t actual);
        if ({actual.addr_ok, actual.data_ok} !== {expected.addr_ok, expected.data_ok}) begin
            $display("** Error %s: expected addr_ok=%b data_ok=%b actual addr_ok=%b data_ok=%b",
                     name, expected.addr_ok, expected.data_ok, actual.addr_ok, actual.data_ok);
            abort_run();
        end
    endtask

    // called on a falling edge, returns on the falling edge after the accept
    task automatic issue(input sram_port_e port, input logic wr, input addr_t addr,
                         input strb_t strb, input word_t wdata, output int unsigned ok_cycle);
        sram_req_t rq;
        int        waited;
        rq = '{req: 1'b1, wr: wr, addr: addr, wstrb: strb, wdata: wdata};
        if (port == PORT_DATA) data_req = rq;
        else inst_req = rq;
        waited = 0;
        do begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: no addr_ok on the %s port for address %08h in %s",
                         port.name(), addr, test_name);
                abort_run();
            end
        end while (!((port == PORT_DATA) ? data_rsp.addr_ok : inst_rsp.addr_ok));
        ok_cycle = cycle_count;
        @(negedge aclk);   // handshake edge has passed
        if (port == PORT_DATA) data_req = '0;
        else inst_req = '0;
    endtask

    task automatic write_word(addr_t addr, strb_t strb, word_t wdata);
        int unsigned t;
        issue(PORT_DATA, 1'b1, addr, strb, wdata, t);
    endtask

    task automatic read_word(sram_port_e port, addr_t addr);
        int unsigned t;
        issue(port, 1'b0, addr, '0, '0, t);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (inst_q.size() != 0 || data_q.size() != 0) begin
            @(negedge aclk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout: %0d inst and %0d data responses never arrived in %s",
                         inst_q.size(), data_q.size(), test_name);
                abort_run();
            end
        end
    endtask

    // scoreboard, outputs are settled mid-cycle
    always @(negedge aclk) begin
        expect_t head;
        expect_t entry;
        if (aresetn) begin
            if (inst_rsp.data_ok) begin
                if (inst_q.size() == 0) begin
                    $display("inst port gave a data_ok with nothing outstanding in %s", test_name);
                    abort_run();
                end
                head = inst_q.pop_front();
                check_rdata($sformatf("%s inst read", test_name), head.value, inst_rsp.rdata);
            end
            if (data_rsp.data_ok) begin
                if (data_q.size() == 0) begin
                    $display("data port gave a data_ok with nothing outstanding in %s", test_name);
                    abort_run();
                end
                head = data_q.pop_front();
                if (!head.is_wr) begin
                    check_rdata($sformatf("%s data read", test_name), head.value, data_rsp.rdata);
                end
            end
            // a write accepted in the same cycle as a read lands first
            if (data_rsp.addr_ok) begin
                entry.is_wr = data_req.wr;
                entry.value = '0;
                if (data_req.wr) ref_write(data_req);
                else entry.value = ref_read(data_req.addr);
                data_q.push_back(entry);
            end
            if (inst_rsp.addr_ok) begin
                entry.is_wr = 1'b0;
                entry.value = ref_read(inst_req.addr);
                inst_q.push_back(entry);
            end
        end
    end

    initial begin
        int unsigned t_inst;
        int unsigned t_data;
        addr_t       a;

        void'($urandom(15982));
        aresetn  = 1'b0;
        inst_req = '0;
        data_req = '0;
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        test_name = "reset_idle";
        repeat (5) begin
            @(negedge aclk);
            check_rsp_idle("reset_idle inst", '0, inst_rsp);
            check_rsp_idle("reset_idle data", '0, data_rsp);
        end

        test_name = "full_word";
        for (int i = 0; i < WIN_WORDS; i++) begin
            a = WIN_BASE + addr_t'(i * 4);
            write_word(a, '1, fill_word(a));
        end
        for (int i = 0; i < WIN_WORDS; i++) begin
            read_word(PORT_DATA, WIN_BASE + addr_t'(i * 4));
        end
        wait_drain();

        test_name = "strobe_merge";
        repeat (40) begin
            write_word(rand_addr(), strb_t'($urandom()), word_t'($urandom()));
        end
        for (int i = 0; i < WIN_WORDS; i++) begin
            read_word(PORT_DATA, WIN_BASE + addr_t'(i * 4));
        end
        wait_drain();

        test_name = "inst_read";
        for (int i = 0; i < WIN_WORDS; i++) begin
            read_word(PORT_INST, WIN_BASE + addr_t'(i * 4));
        end
        wait_drain();

        test_name = "read_tie";
        repeat (6) begin
            fork
                issue(PORT_INST, 1'b0, rand_addr(), '0, '0, t_inst);
                issue(PORT_DATA, 1'b0, rand_addr(), '0, '0, t_data);
            join
            if (t_data > t_inst) begin
                $display("data port addr_ok at cycle %0d came after the inst port's at %0d",
                         t_data, t_inst);
                abort_run();
            end
            wait_drain();
        end

        // the read is held until the write response
        test_name = "write_then_read";
        repeat (12) begin
            a = rand_addr();
            write_word(a, strb_t'($urandom()), word_t'($urandom()));
            read_word(PORT_DATA, a);
            a = rand_addr();
            write_word(a, strb_t'($urandom()), word_t'($urandom()));
            read_word(PORT_INST, a);
        end
        wait_drain();

        test_name = "random_mix";
        fork
            begin
                for (int n = 0; n < 100; n++) begin
                    repeat ($urandom_range(0, 2)) @(negedge aclk);
                    read_word(PORT_INST, rand_addr());
                end
            end
            begin
                for (int n = 0; n < 200; n++) begin
                    repeat ($urandom_range(0, 2)) @(negedge aclk);
                    if ($urandom_range(0, 1) == 1) begin
                        write_word(rand_addr(), strb_t'($urandom()), word_t'($urandom()));
                    end else begin
                        read_word(PORT_DATA, rand_addr());
                    end
                end
            end
        join
        wait_drain();

        test_name = "final";
        repeat (20) @(negedge aclk);   // quiet period, a stray data_ok shows up here
        if (inst_q.size() != 0 || data_q.size() != 0) begin
            $display("%0d inst and %0d data responses still owed at the end",
                     inst_q.size(), data_q.size());
            abort_run();
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+include
source/axi_pkg.sv
source/sram_if_pkg.sv
source/sram_req_arbiter.sv
source/axi_read_master.sv
source/axi_write_master.sv
source/axi_word_ram.sv
source/sram_axi_bridge_top.sv
bench/tb_bridge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_bridge
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
